/* tb.f */
+incdir+include
logic/subword_pkg.sv
logic/credit_fifo.sv
logic/word_mem.sv
logic/mem_arbiter.sv
logic/subword_sequencer.sv
logic/subword_store_top.sv
sim/clock_gen.sv
sim/subword_chk.sv
sim/tb_subword_store.sv

/* Makefile */
# Verilator build and run for the sub-word store testbench
VERILATOR ?= verilator
TOP       ?= tb_subword_store
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_STR  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_subword_store.sv */
// testbench for subword_store_top, drives both ports and checks loads against a shadow memory
`timescale 1ns/1ps
`default_nettype none

`include "subword_defs.svh"

module tb_subword_store;

  import subword_pkg::*;

  localparam int clk_period_ns  = 8;
  localparam int n_directed     = 19;
  localparam int n_backpress    = 18;
  localparam int n_random       = 100;
  localparam int n_cmds         = `SW_PORTS * (n_directed + n_backpress + n_random);
  localparam int words_per_port = `SW_WORDS / `SW_PORTS;

  logic     clk;
  logic     reset;
  logic     cmd_valid  [`SW_PORTS];
  mem_cmd_t cmd        [`SW_PORTS];
  logic     cmd_credit [`SW_PORTS];
  logic     rsp_valid  [`SW_PORTS];
  mem_rsp_t rsp        [`SW_PORTS];
  logic     rsp_credit [`SW_PORTS];

  // commands not yet sent and load results still expected, per port
  mem_cmd_t    cmd_q [`SW_PORTS][$];
  mem_rsp_t    exp_q [`SW_PORTS][$];
  logic [31:0] shadow [`SW_WORDS];
  int          credits [`SW_PORTS];
  int          owed [`SW_PORTS];
  int          rsp_seen [`SW_PORTS];
  int          seen_at_hold [`SW_PORTS];
  int          errors;
  int          n_checked;
  bit          hold_rsp;
  bit          reported;

  clock_gen #(.period_ns(clk_period_ns), .reset_cycles(4)) u_clk (
    .clk   (clk),
    .reset (reset)
  );

  subword_store_top u_dut (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_credit (cmd_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_credit (rsp_credit)
  );

  bind subword_store_top subword_chk u_chk (
    .clk        (clk),
    .reset      (reset),
    .gnt        (seq_gnt),
    .req        (seq_req),
    .cmd_credit (cmd_credit),
    .rsp_valid  (rsp_valid),
    .rsp_credit (rsp_credit)
  );

  // little-endian lane rules, halfword stores ignore address bit 0
  function automatic logic [31:0] expect_word(input logic [31:0] old_word, input mem_op_e op,
                                              input logic [9:0] addr, input logic [31:0] data);
    logic [31:0] w;
    w = old_word;
    case (op)
      op_sw: w = data;
      op_sh: begin
        if (addr[1]) w[31:16] = data[15:0];
        else w[15:0] = data[15:0];
      end
      op_sb: begin
        case (addr[1:0])
          2'd0: w[7:0] = data[7:0];
          2'd1: w[15:8] = data[7:0];
          2'd2: w[23:16] = data[7:0];
          default: w[31:24] = data[7:0];
        endcase
      end
      default: w = old_word;
    endcase
    return w;
  endfunction

  task automatic check_val(input string what, input int port, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: port %0d %s, got %h expected %h", $time, port, what, got, exp);
    end
  endtask

  // loads capture the shadow word now, stores update it in program order
  task automatic queue_cmd(input int p, input mem_op_e op, input int waddr, input int offs,
                           input logic [31:0] data);
    mem_cmd_t c;
    mem_rsp_t r;
    c.op   = op;
    c.addr = 10'(waddr * 4 + offs);
    c.data = data;
    if (op == op_lw) begin
      r.addr = c.addr;
      r.data = shadow[waddr];
      exp_q[p].push_back(r);
    end else begin
      shadow[waddr] = expect_word(shadow[waddr], op, c.addr, data);
    end
    cmd_q[p].push_back(c);
  endtask

  task automatic wait_drained();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      busy = 1'b0;
      for (int p = 0; p < `SW_PORTS; p++) begin
        if (cmd_q[p].size() != 0 || exp_q[p].size() != 0) busy = 1'b1;
        if (credits[p] != `SW_Q_DEPTH || owed[p] != 0) busy = 1'b1;
      end
    end
  endtask

  // stimulus on the falling edge, one command beat per credit
  always @(negedge clk) begin
    for (int p = 0; p < `SW_PORTS; p++) begin
      if (!reset && cmd_q[p].size() > 0 && credits[p] > 0) begin
        cmd_valid[p] = 1'b1;
        cmd[p]       = cmd_q[p].pop_front();
        credits[p]--;
      end else begin
        cmd_valid[p] = 1'b0;
      end
      if (!reset && owed[p] > 0 && !hold_rsp && $urandom_range(3, 0) != 0) begin
        rsp_credit[p] = 1'b1;
        owed[p]--;
      end else begin
        rsp_credit[p] = 1'b0;
      end
    end
  end

  // compare process, samples the values present before the rising edge
  always @(posedge clk) begin
    mem_rsp_t e;
    if (!reset) begin
      for (int p = 0; p < `SW_PORTS; p++) begin
        if (cmd_credit[p]) credits[p]++;
        if (credits[p] > `SW_Q_DEPTH) begin
          errors++;
          $display("port %0d returned a command credit that was never spent", p);
        end
        if (rsp_valid[p]) begin
          rsp_seen[p]++;
          owed[p]++;
          if (exp_q[p].size() == 0) begin
            errors++;
            $display("port %0d sent a response that no load asked for", p);
          end else begin
            e = exp_q[p].pop_front();
            check_val("response address", p, 32'(rsp[p].addr), 32'(e.addr));
            check_val("load data", p, rsp[p].data, e.data);
            n_checked++;
          end
        end
      end
    end
  end

  initial begin
    #(n_cmds * 40 * clk_period_ns);
    $display("watchdog expired, the DUT stopped making progress");
    reported = 1'b1;
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int base;
    int waddr;
    int offs;
    mem_op_e op;
    errors    = 0;
    n_checked = 0;
    hold_rsp  = 1'b0;
    reported  = 1'b0;
    for (int p = 0; p < `SW_PORTS; p++) begin
      cmd_valid[p]  = 1'b0;
      cmd[p]        = '0;
      rsp_credit[p] = 1'b0;
      credits[p]    = `SW_Q_DEPTH;
      owed[p]       = 0;
      rsp_seen[p]   = 0;
    end
    for (int i = 0; i < `SW_WORDS; i++) shadow[i] = 32'h0;
    void'($urandom(32'hfe6be52f));

    while (reset) @(negedge clk);
    for (int p = 0; p < `SW_PORTS; p++) begin
      check_val("cmd_credit after reset", p, 32'(cmd_credit[p]), 32'h0);
      check_val("rsp_valid after reset", p, 32'(rsp_valid[p]), 32'h0);
    end

    // directed: cleared memory, word access, byte lanes, halfword lanes
    for (int p = 0; p < `SW_PORTS; p++) begin
      base = p * words_per_port;
      queue_cmd(p, op_lw, base, 0, 0);
      queue_cmd(p, op_lw, base + 5, 0, 0);
      queue_cmd(p, op_lw, base + words_per_port - 1, 0, 0);
      queue_cmd(p, op_sw, base + 1, 0, 32'h1234_5678 ^ p);
      queue_cmd(p, op_lw, base + 1, 0, 0);
      queue_cmd(p, op_sw, base + 2, 0, 32'ha5a5_5a5a);
      for (int lane = 0; lane < 4; lane++) begin
        queue_cmd(p, op_sb, base + 2, lane, 32'hffff_ff10 + lane + p * 16);
        queue_cmd(p, op_lw, base + 2, 0, 0);
      end
      queue_cmd(p, op_sw, base + 3, 0, 32'h0bad_f00d);
      queue_cmd(p, op_sh, base + 3, 1, 32'h7777_beef);
      queue_cmd(p, op_lw, base + 3, 0, 0);
      queue_cmd(p, op_sh, base + 3, 3, 32'h0000_cafe ^ p);
      queue_cmd(p, op_lw, base + 3, 0, 0);
    end
    wait_drained();

    // response back-pressure, enough loads to fill both queues and use up the credits
    hold_rsp = 1'b1;
    for (int p = 0; p < `SW_PORTS; p++) begin
      base            = p * words_per_port;
      seen_at_hold[p] = rsp_seen[p];
      queue_cmd(p, op_sw, base + 10, 0, 32'hdead_0000 + p);
      queue_cmd(p, op_sb, base + 11, 2, 32'h0000_00c3);
      for (int i = 0; i < 16; i++) queue_cmd(p, op_lw, base + 10 + (i % 2), 0, 0);
    end
    repeat (80) @(negedge clk);
    for (int p = 0; p < `SW_PORTS; p++) begin
      check_val("command credits while stalled", p, 32'(credits[p]), 32'h0);
      check_val("responses while stalled", p, 32'(rsp_seen[p] - seen_at_hold[p]),
                32'(`SW_Q_DEPTH));
    end
    hold_rsp = 1'b0;
    wait_drained();

    // random mixed traffic, both ports at once on a few words each
    for (int i = 0; i < n_random; i++) begin
      for (int p = 0; p < `SW_PORTS; p++) begin
        case ($urandom_range(3, 0))
          0: op = op_lw;
          1: op = op_sw;
          2: op = op_sh;
          default: op = op_sb;
        endcase
        waddr = p * words_per_port + $urandom_range(15, 0);
        offs  = (op == op_lw || op == op_sw) ? 0 : $urandom_range(3, 0);
        queue_cmd(p, op, waddr, offs, $urandom);
      end
    end
    wait_drained();

    $display("errors: %0d  responses checked: %0d", errors, n_checked);
    reported = 1'b1;
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // a run stopped early by a failed assertion still ends with a verdict
  final begin
    if (!reported) $display("TEST RESULT: FAIL");
  end

endmodule

`default_nettype wire

/* sim/subword_chk.sv */
// concurrent checks on arbiter grants and credit ports that are bound into subword_store_top
`timescale 1ns/1ps
`default_nettype none

`include "subword_defs.svh"

module subword_chk (
  input logic                  clk,
  input logic                  reset,
  input logic [1:0]            gnt,
  input subword_pkg::mem_req_t req        [`SW_PORTS],
  input logic                  cmd_credit [`SW_PORTS],
  input logic                  rsp_valid  [`SW_PORTS],
  input logic                  rsp_credit [`SW_PORTS]
);

  // at most one sequencer owns the memory in any cycle
  a_gnt_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(gnt))
    else $error("arbiter granted more than one sequencer");

  for (genvar p = 0; p < `SW_PORTS; p++) begin : g_port
    // response credits the DUT holds
    logic [2:0] credits;
    // high from a granted locked read until the same port's store is granted
    logic       rmw_open;

    always_ff @(posedge clk) begin
      if (reset) begin
        credits <= 3'(`SW_Q_DEPTH);
      end else begin
        credits <= credits + 3'(rsp_credit[p]) - 3'(rsp_valid[p]);
      end
    end

    always_ff @(posedge clk) begin
      if (reset) begin
        rmw_open <= 1'b0;
      end else if (gnt[p]) begin
        rmw_open <= req[p].lock;
      end
    end

    a_rsp_has_credit: assert property (
      @(posedge clk) disable iff (reset) rsp_valid[p] |-> credits != 3'd0)
      else $error("port %0d sent a response without holding a credit", p);

    a_rmw_atomic: assert property (
      @(posedge clk) disable iff (reset) rmw_open |-> !gnt[1 - p])
      else $error("port %0d lost the memory in the middle of a read-modify-write", p);

    a_quiet_after_reset: assert property (
      @(posedge clk) $past(reset) |-> !rsp_valid[p] && !cmd_credit[p])
      else $error("port %0d output active right after reset", p);
  end

endmodule

`default_nettype wire

/* sim/clock_gen.sv */
// testbench clock and reset source, instantiated once by the top-level testbench
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int period_ns    = 8,
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2.0) clk = ~clk;
  end

  // released with a nonblocking update so the last reset edge still sees it high
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

/* logic/subword_store_top.sv */
// top level with two credit ports, their sequencers, the arbiter and the shared word memory
`timescale 1ns/1ps
`default_nettype none

`include "subword_defs.svh"

module subword_store_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cmd_valid  [`SW_PORTS],
  input  subword_pkg::mem_cmd_t cmd        [`SW_PORTS],
  output logic                  cmd_credit [`SW_PORTS],
  output logic                  rsp_valid  [`SW_PORTS],
  output subword_pkg::mem_rsp_t rsp        [`SW_PORTS],
  input  logic                  rsp_credit [`SW_PORTS]
);

  import subword_pkg::*;

  mem_req_t              seq_req [`SW_PORTS];
  logic [`SW_PORTS-1:0]  seq_gnt;
  mem_req_t              mem_req;
  logic [31:0]           mem_rdata;

  // one sequencer per requester, all see the same read data
  for (genvar p = 0; p < `SW_PORTS; p++) begin : g_port
    subword_sequencer u_seq (
      .clk        (clk),
      .reset      (reset),
      .cmd_valid  (cmd_valid[p]),
      .cmd        (cmd[p]),
      .cmd_credit (cmd_credit[p]),
      .rsp_valid  (rsp_valid[p]),
      .rsp        (rsp[p]),
      .rsp_credit (rsp_credit[p]),
      .req        (seq_req[p]),
      .gnt        (seq_gnt[p]),
      .rdata      (mem_rdata)
    );
  end

  mem_arbiter u_arb (
    .clk     (clk),
    .reset   (reset),
    .req     (seq_req),
    .gnt     (seq_gnt),
    .mem_req (mem_req)
  );

  word_mem u_mem (
    .clk   (clk),
    .reset (reset),
    .req   (mem_req),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

/* logic/subword_sequencer.sv */
// per-port engine that runs queued commands in order and turns sb/sh into read, merge and write
`timescale 1ns/1ps
`default_nettype none

`include "subword_defs.svh"

module subword_sequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cmd_valid,
  input  subword_pkg::mem_cmd_t cmd,
  output logic                  cmd_credit,
  output logic                  rsp_valid,
  output subword_pkg::mem_rsp_t rsp,
  input  logic                  rsp_credit,
  output subword_pkg::mem_req_t req,
  input  logic                  gnt,
  input  logic [31:0]           rdata
);

  import subword_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_read,
    st_wait,
    st_merge,
    st_write
  } seq_state_e;

  seq_state_e  state_q;
  seq_state_e  state_d;
  mem_cmd_t    cmd_head;
  mem_rsp_t    rsp_entry;
  logic        cmd_empty;
  logic [2:0]  cmd_count;
  logic        cmd_pop;
  logic        cmd_more;
  logic        rsp_empty;
  logic [2:0]  rsp_count;
  logic        rsp_push;
  logic [2:0]  rsp_credits;
  logic        lw_slot_free;
  logic [31:0] word_q;

  // place the byte or halfword into its lane and keep the other lanes of the word just read
  function automatic logic [31:0] merge_lanes(input logic [31:0] old_word, input mem_cmd_t c);
    logic [31:0] merged;
    merged = old_word;
    if (c.op == op_sb) begin
      merged[{c.addr[1:0], 3'b000} +: 8] = c.data[7:0];
    end else begin
      // halfword store ignores address bit 0
      merged[{c.addr[1], 4'b0000} +: 16] = c.data[15:0];
    end
    return merged;
  endfunction

  credit_fifo #(.payload_t(mem_cmd_t)) u_cmd_q (
    .clk       (clk),
    .reset     (reset),
    .push      (cmd_valid),
    .push_data (cmd),
    .pop       (cmd_pop),
    .pop_data  (cmd_head),
    .empty     (cmd_empty),
    .count     (cmd_count)
  );

  credit_fifo #(.payload_t(mem_rsp_t)) u_rsp_q (
    .clk       (clk),
    .reset     (reset),
    .push      (rsp_push),
    .push_data (rsp_entry),
    .pop       (rsp_valid),
    .pop_data  (rsp),
    .empty     (rsp_empty),
    .count     (rsp_count)
  );

  assign cmd_credit = cmd_pop;
  assign cmd_more   = (cmd_count > 3'd1) || cmd_valid;
  assign rsp_entry  = '{addr: cmd_head.addr, data: rdata};
  assign rsp_valid  = !rsp_empty && (rsp_credits != 3'd0);

  // a load starts only while the response queue has room for its result
  assign lw_slot_free = rsp_count < 3'(`SW_Q_DEPTH);

  always_comb begin
    state_d   = state_q;
    cmd_pop   = 1'b0;
    rsp_push  = 1'b0;
    req       = '0;
    req.waddr = cmd_head.addr[`SW_ADDR_W-1:2];
    unique case (state_q)
      st_idle: begin
        if (cmd_valid || !cmd_empty) state_d = st_read;
      end
      st_read: begin
        // first access of the head command
        unique case (cmd_head.op)
          op_sw: begin
            req.valid = 1'b1;
            req.we    = 1'b1;
            req.wdata = cmd_head.data;
            cmd_pop   = gnt;
          end
          op_lw: begin
            req.valid = lw_slot_free;
            if (gnt) state_d = st_wait;
          end
          default: begin
            req.valid = 1'b1;
            req.lock  = 1'b1;
            if (gnt) state_d = st_wait;
          end
        endcase
      end
      st_wait: begin
        if (cmd_head.op == op_lw) begin
          rsp_push = 1'b1;
          cmd_pop  = 1'b1;
        end else begin
          state_d = st_merge;
        end
      end
      st_merge: state_d = st_write;
      st_write: begin
        req.valid = 1'b1;
        req.we    = 1'b1;
        req.wdata = word_q;
        cmd_pop   = gnt;
      end
      default: state_d = st_idle;
    endcase
    if (cmd_pop) state_d = cmd_more ? st_read : st_idle;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q     <= st_idle;
      rsp_credits <= 3'(`SW_Q_DEPTH);
    end else begin
      state_q     <= state_d;
      rsp_credits <= rsp_credits + 3'(rsp_credit) - 3'(rsp_valid);
    end
  end

  // holds the word read for a merge and then the merged result
  always_ff @(posedge clk) begin
    if (state_q == st_wait) word_q <= rdata;
    else if (state_q == st_merge) word_q <= merge_lanes(word_q, cmd_head);
  end

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
// round-robin arbiter that gives word_mem to one sequencer and keeps it across a locked read
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic                  clk,
  input  logic                  reset,
  input  subword_pkg::mem_req_t req [2],
  output logic [1:0]            gnt,
  output subword_pkg::mem_req_t mem_req
);

  // port that made the last unlocked access
  logic last_served;
  // a read-modify-write is in progress for lock_owner
  logic lock_active;
  logic lock_owner;
  // port considered for the grant this cycle
  logic pick;

  always_comb begin
    gnt  = 2'b00;
    pick = ~last_served;
    if (lock_active) begin
      // only the owner may touch memory until its store goes through
      pick = lock_owner;
    end else if (req[0].valid && req[1].valid) begin
      pick = ~last_served;
    end else begin
      pick = req[1].valid;
    end
    gnt[pick] = req[pick].valid;
  end

  assign mem_req = (gnt != 2'b00) ? req[pick] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      last_served <= 1'b1;
      lock_active <= 1'b0;
      lock_owner  <= 1'b0;
    end else if (gnt != 2'b00) begin
      if (req[pick].lock) begin
        lock_active <= 1'b1;
        lock_owner  <= pick;
      end else begin
        // priority only moves once an access completes unlocked
        lock_active <= 1'b0;
        last_served <= pick;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/word_mem.sv */
// shared 32-bit data memory, written on the granted edge and read one cycle after a granted read
`timescale 1ns/1ps
`default_nettype none

`include "subword_defs.svh"

module word_mem (
  input  logic                  clk,
  input  logic                  reset,
  input  subword_pkg::mem_req_t req,
  output logic [31:0]           rdata
);

  logic [31:0] words [`SW_WORDS];

  // reset walks the whole array so every word reads back as zero
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `SW_WORDS; i++) begin
        words[i] <= 32'b0;
      end
      rdata <= 32'b0;
    end else if (req.valid) begin
      if (req.we) begin
        words[req.waddr] <= req.wdata;
      end else begin
        // registered read, rdata holds until the next read
        rdata <= words[req.waddr];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/credit_fifo.sv */
// small synchronous FIFO with a typed payload, holds commands or responses behind a credit port
`timescale 1ns/1ps
`default_nettype none

`include "subword_defs.svh"

module credit_fifo #(
  parameter type payload_t = subword_pkg::mem_cmd_t
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic [2:0] count
);

  localparam int ptr_w = $clog2(`SW_Q_DEPTH);

  payload_t         slots [`SW_Q_DEPTH];
  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] tail;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign empty   = (count == 3'd0);
  assign full    = (count == 3'(`SW_Q_DEPTH));
  // push on a full queue and pop on an empty one are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // head entry is visible without a pop
  assign pop_data = slots[head];

  always_ff @(posedge clk) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= 3'd0;
    end else begin
      if (do_push) tail <= tail + 1'b1;
      if (do_pop) head <= head + 1'b1;
      count <= count + 3'(do_push) - 3'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) slots[tail] <= push_data;
  end

endmodule

`default_nettype wire

/* logic/subword_pkg.sv */
// command, response and memory request types shared by the sequencers, arbiter and memory
`default_nettype none

`include "subword_defs.svh"

package subword_pkg;

  // memory operations a requester can issue
  typedef enum logic [1:0] {
    op_lw = 2'd0,
    op_sw = 2'd1,
    op_sh = 2'd2,
    op_sb = 2'd3
  } mem_op_e;

  // one requester command; byte data in 7:0, halfword data in 15:0
  typedef struct packed {
    mem_op_e                op;
    logic [`SW_ADDR_W-1:0]  addr;
    logic [31:0]            data;
  } mem_cmd_t;

  // load response, always a whole word
  typedef struct packed {
    logic [`SW_ADDR_W-1:0]  addr;
    logic [31:0]            data;
  } mem_rsp_t;

  // word-wide access from a sequencer toward word_mem
  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic                   lock;
    logic [`SW_ADDR_W-3:0]  waddr;
    logic [31:0]            wdata;
  } mem_req_t;

endpackage

`default_nettype wire

/* include/subword_defs.svh */
// size and depth constants for the sub-word store subsystem, included by the package and RTL
`ifndef SUBWORD_DEFS_SVH
`define SUBWORD_DEFS_SVH

// byte address width, 1 KiB of data memory
`define SW_ADDR_W 10

// number of 32-bit words in word_mem
`define SW_WORDS 256

// entries per command or response queue
// also the credit count each side starts with
// keep this a power of two, the FIFO pointers wrap naturally
`define SW_Q_DEPTH 4

// number of requesters, each with its own sequencer
`define SW_PORTS 2

`endif
